/* source/gpio_params.svh */
// GPIO sizes and register map
`ifndef GPIO_PARAMS_SVH
`define GPIO_PARAMS_SVH

// pin count
`define GPIO_WIDTH 12

// request port widths
`define GPIO_ADDR_BITS 12
`define GPIO_DATA_BITS 64
`define GPIO_STRB_BITS (`GPIO_DATA_BITS/8)
`define GPIO_HALF_BITS (`GPIO_DATA_BITS/2)  // lower/upper word split

// word index field of the address
`define GPIO_IDX_MSB 11
`define GPIO_IDX_LSB 3
`define GPIO_IDX_BITS (`GPIO_IDX_MSB-`GPIO_IDX_LSB+1)

// register word indices
`define GPIO_REG_DIR 9'd0  // direction / input levels
`define GPIO_REG_OUT 9'd1  // output level / scratch
`define GPIO_REG_IRQ 9'd2  // enable / pending

`endif

/* source/gpio_pkg.sv */
// GPIO shared types
package gpio_pkg;

  // kind of access presented to the register bank
  typedef enum logic [1:0] {
    op_none,   // idle cycle
    op_read,
    op_write
  } gpio_op_e;

  // register word selected by the address index
  typedef enum logic [1:0] {
    sel_dir,   // index 0
    sel_out,   // index 1
    sel_irq,   // index 2
    sel_bad    // unmapped, answers with err
  } gpio_sel_e;

  // first the op, then the word it targets
  typedef struct packed {
    gpio_op_e  op;
    gpio_sel_e sel;
  } gpio_acc_t;

  localparam gpio_acc_t GPIO_ACC_IDLE = '{op: op_none, sel: sel_bad};

endpackage : gpio_pkg

/* source/gpio_req_if.sv */
// Decoded register access bus
`include "gpio_params.svh"

interface gpio_req_if;

  gpio_pkg::gpio_op_e              op;     // from control
  gpio_pkg::gpio_sel_e             sel;    // decoded word
  logic [`GPIO_DATA_BITS-1:0]      wdata;
  logic [`GPIO_STRB_BITS-1:0]      wstrb;
  logic [`GPIO_DATA_BITS-1:0]      rdata;  // registered read data

  // request decoder side
  modport ctrl (
    output op,
    output sel,
    output wdata,
    output wstrb,
    input  rdata
  );

  // register bank side
  modport regs (
    input  op,
    input  sel,
    input  wdata,
    input  wstrb,
    output rdata
  );

endinterface : gpio_req_if

/* source/gpio_in_sync.sv */
// GPIO input synchronizer
`include "gpio_params.svh"

module gpio_in_sync (
  input  logic                    clk,
  input  logic                    nrst,
  input  logic [`GPIO_WIDTH-1:0]  i_gpio,
  output logic [`GPIO_WIDTH-1:0]  o_sync,
  output logic [`GPIO_WIDTH-1:0]  o_rise
);

  logic [`GPIO_WIDTH-1:0] meta_q;  // first stage, may go metastable
  logic [`GPIO_WIDTH-1:0] sync_q;  // second stage, safe to use
  logic [`GPIO_WIDTH-1:0] prev_q;  // last synchronized level

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= i_gpio;
      sync_q <= meta_q;
    end
  end

  // edge detector runs on the clean level
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      prev_q <= '0;
    end else begin
      prev_q <= sync_q;
    end
  end

  assign o_sync = sync_q;
  assign o_rise = sync_q & ~prev_q;  // high for one cycle per low-to-high

endmodule : gpio_in_sync

/* source/gpio_ctrl.sv */
// GPIO request decoder
`include "gpio_params.svh"

module gpio_ctrl (
  input  logic                        clk,
  input  logic                        nrst,
  input  logic                        i_req_valid,
  input  logic                        i_req_write,
  input  logic [`GPIO_ADDR_BITS-1:0]  i_req_addr,
  input  logic [`GPIO_DATA_BITS-1:0]  i_req_wdata,
  input  logic [`GPIO_STRB_BITS-1:0]  i_req_wstrb,
  gpio_req_if.ctrl                    bus,
  output logic                        o_resp_valid,
  output logic                        o_resp_err
);

  gpio_pkg::gpio_acc_t        acc;
  logic [`GPIO_IDX_BITS-1:0]  idx;
  logic                       resp_valid_q;
  logic                       resp_err_q;
  logic                       bad_req;

  assign idx = i_req_addr[`GPIO_IDX_MSB:`GPIO_IDX_LSB];  // 64-bit word index

  // classify the request and pick the register word
  always_comb begin
    acc = gpio_pkg::GPIO_ACC_IDLE;
    if (i_req_valid) begin
      if (i_req_write) begin
        acc.op = gpio_pkg::op_write;
      end else begin
        acc.op = gpio_pkg::op_read;
      end
    end
    case (idx)
      `GPIO_REG_DIR: acc.sel = gpio_pkg::sel_dir;
      `GPIO_REG_OUT: acc.sel = gpio_pkg::sel_out;
      `GPIO_REG_IRQ: acc.sel = gpio_pkg::sel_irq;
      default:       acc.sel = gpio_pkg::sel_bad;
    endcase
  end

  assign bad_req = (acc.op != gpio_pkg::op_none) && (acc.sel == gpio_pkg::sel_bad);

  // decoded access goes straight to the bank
  assign bus.op    = acc.op;
  assign bus.sel   = acc.sel;
  assign bus.wdata = i_req_wdata;
  assign bus.wstrb = i_req_wstrb;

  // response one cycle after the request, no stall
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      resp_valid_q <= 1'b0;
      resp_err_q   <= 1'b0;
    end else begin
      resp_valid_q <= (acc.op != gpio_pkg::op_none);
      resp_err_q   <= bad_req;  // unmapped index
    end
  end

  assign o_resp_valid = resp_valid_q;
  assign o_resp_err   = resp_err_q;

endmodule : gpio_ctrl

/* source/gpio_regs.sv */
// GPIO register bank
`include "gpio_params.svh"

module gpio_regs (
  input  logic                    clk,
  input  logic                    nrst,
  gpio_req_if.regs                bus,
  input  logic [`GPIO_WIDTH-1:0]  i_sync,
  input  logic [`GPIO_WIDTH-1:0]  i_rise,
  output logic [`GPIO_WIDTH-1:0]  o_gpio,
  output logic [`GPIO_WIDTH-1:0]  o_gpio_dir,
  output logic [`GPIO_WIDTH-1:0]  o_irq
);

  logic [`GPIO_WIDTH-1:0]     dir_q;
  logic [`GPIO_WIDTH-1:0]     out_q;
  logic [`GPIO_HALF_BITS-1:0] scratch_q;
  logic [`GPIO_WIDTH-1:0]     ie_q;
  logic [`GPIO_WIDTH-1:0]     pend_q;
  logic [`GPIO_WIDTH-1:0]     pend_set;
  logic [`GPIO_WIDTH-1:0]     pend_clr;
  logic [`GPIO_DATA_BITS-1:0] rd_mux;
  logic [`GPIO_DATA_BITS-1:0] rdata_q;
  logic [`GPIO_WIDTH-1:0]     wr_lo_data;
  logic [`GPIO_WIDTH-1:0]     wr_hi_data;
  logic                       wr;
  logic                       wr_lo;
  logic                       wr_hi;
  logic                       dir_we;
  logic                       out_we;
  logic                       scratch_we;
  logic                       ie_we;
  logic                       pend_we;

  assign wr    = (bus.op == gpio_pkg::op_write);
  assign wr_lo = wr && (|bus.wstrb[`GPIO_STRB_BITS/2-1:0]);
  assign wr_hi = wr && (|bus.wstrb[`GPIO_STRB_BITS-1:`GPIO_STRB_BITS/2]);

  assign wr_lo_data = bus.wdata[`GPIO_WIDTH-1:0];
  assign wr_hi_data = bus.wdata[`GPIO_HALF_BITS +: `GPIO_WIDTH];

  // word enables follow the decoded select only
  assign dir_we     = wr_lo && (bus.sel == gpio_pkg::sel_dir);
  assign out_we     = wr_lo && (bus.sel == gpio_pkg::sel_out);
  assign scratch_we = wr_hi && (bus.sel == gpio_pkg::sel_out);
  assign ie_we      = wr_lo && (bus.sel == gpio_pkg::sel_irq);
  assign pend_we    = wr_hi && (bus.sel == gpio_pkg::sel_irq);

  assign pend_set = i_rise & dir_q;                      // input pins only
  assign pend_clr = pend_we ? wr_hi_data : '0;           // write one to clear

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      dir_q     <= '1;  // all pins start as inputs
      out_q     <= '0;
      scratch_q <= '0;
      ie_q      <= '0;
      pend_q    <= '0;
    end else begin
      if (dir_we)     dir_q     <= wr_lo_data;
      if (out_we)     out_q     <= wr_lo_data;
      if (scratch_we) scratch_q <= bus.wdata[`GPIO_DATA_BITS-1:`GPIO_HALF_BITS];
      if (ie_we)      ie_q      <= wr_lo_data;
      pend_q <= (pend_q & ~pend_clr) | pend_set;  // set beats clear
    end
  end

  // read side sees the values before this cycle's write
  always_comb begin
    rd_mux = '0;
    case (bus.sel)
      gpio_pkg::sel_dir: begin
        rd_mux[`GPIO_WIDTH-1:0]                 = dir_q;
        rd_mux[`GPIO_HALF_BITS +: `GPIO_WIDTH]  = i_sync;  // read only
      end
      gpio_pkg::sel_out: begin
        rd_mux[`GPIO_WIDTH-1:0]                       = out_q;
        rd_mux[`GPIO_DATA_BITS-1:`GPIO_HALF_BITS]     = scratch_q;
      end
      gpio_pkg::sel_irq: begin
        rd_mux[`GPIO_WIDTH-1:0]                 = ie_q;
        rd_mux[`GPIO_HALF_BITS +: `GPIO_WIDTH]  = pend_q;
      end
      default: ;  // unmapped reads zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (bus.op != gpio_pkg::op_none) rdata_q <= rd_mux;
  end

  assign bus.rdata  = rdata_q;
  assign o_gpio     = out_q;
  assign o_gpio_dir = dir_q;
  assign o_irq      = pend_q & ie_q;

endmodule : gpio_regs

/* source/gpio_top.sv */
// GPIO peripheral top level
`include "gpio_params.svh"

module gpio_top (
  input  logic                        clk,
  input  logic                        nrst,
  input  logic                        i_req_valid,
  input  logic                        i_req_write,
  input  logic [`GPIO_ADDR_BITS-1:0]  i_req_addr,
  input  logic [`GPIO_DATA_BITS-1:0]  i_req_wdata,
  input  logic [`GPIO_STRB_BITS-1:0]  i_req_wstrb,
  output logic                        o_resp_valid,
  output logic [`GPIO_DATA_BITS-1:0]  o_resp_rdata,
  output logic                        o_resp_err,
  input  logic [`GPIO_WIDTH-1:0]      i_gpio,
  output logic [`GPIO_WIDTH-1:0]      o_gpio,
  output logic [`GPIO_WIDTH-1:0]      o_gpio_dir,
  output logic [`GPIO_WIDTH-1:0]      o_irq
);

  logic [`GPIO_WIDTH-1:0] sync_lvl;
  logic [`GPIO_WIDTH-1:0] sync_rise;

  gpio_req_if u_bus ();

  gpio_ctrl u_ctrl (
    .clk          (clk),
    .nrst         (nrst),
    .i_req_valid  (i_req_valid),
    .i_req_write  (i_req_write),
    .i_req_addr   (i_req_addr),
    .i_req_wdata  (i_req_wdata),
    .i_req_wstrb  (i_req_wstrb),
    .bus          (u_bus.ctrl),
    .o_resp_valid (o_resp_valid),
    .o_resp_err   (o_resp_err)
  );

  gpio_regs u_regs (
    .clk        (clk),
    .nrst       (nrst),
    .bus        (u_bus.regs),
    .i_sync     (sync_lvl),
    .i_rise     (sync_rise),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir),
    .o_irq      (o_irq)
  );

  gpio_in_sync u_sync (
    .clk    (clk),
    .nrst   (nrst),
    .i_gpio (i_gpio),
    .o_sync (sync_lvl),
    .o_rise (sync_rise)
  );

  assign o_resp_rdata = u_bus.rdata;  // registered in the bank

endmodule : gpio_top

/* testbench/gpio_checker.sv */
// GPIO response checker
`include "gpio_params.svh"

module gpio_checker (
  input  logic                        clk,
  input  logic                        nrst,
  input  logic                        i_resp_valid,
  input  logic [`GPIO_DATA_BITS-1:0]  i_resp_rdata,
  input  logic                        i_resp_err,
  input  logic [`GPIO_WIDTH-1:0]      i_gpio_out,
  input  logic [`GPIO_WIDTH-1:0]      i_gpio_dir,
  input  logic [`GPIO_WIDTH-1:0]      i_irq,
  input  logic [`GPIO_DATA_BITS-1:0]  i_exp_rdata,
  input  logic                        i_exp_chk_rdata,
  input  logic                        i_exp_err,
  input  logic [`GPIO_WIDTH-1:0]      i_exp_gpio,
  input  logic [`GPIO_WIDTH-1:0]      i_exp_dir,
  input  logic [`GPIO_WIDTH-1:0]      i_exp_irq,
  output int                          o_resp_count,
  output int                          o_mismatch_count
);
  timeunit 1ns;
  timeprecision 100ps;

  int responses  = 0;
  int mismatches = 0;

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("Mismatch at %0.1f ns: %s expected %h, got %h", $realtime, name, exp, act);
      mismatches++;
    end
  endtask

  // outputs are sampled one edge after the response registers load
  always @(posedge clk) begin
    if (nrst && i_resp_valid) begin
      if (i_exp_chk_rdata) begin
        compare("o_resp_rdata", i_exp_rdata, i_resp_rdata);
      end
      compare("o_resp_err", i_exp_err, i_resp_err);
      compare("o_gpio", i_exp_gpio, i_gpio_out);
      compare("o_gpio_dir", i_exp_dir, i_gpio_dir);
      compare("o_irq", i_exp_irq, i_irq);
      responses <= responses + 1;
    end
  end

  assign o_resp_count     = responses;
  assign o_mismatch_count = mismatches;

endmodule : gpio_checker

/* testbench/gpio_sva.sv */
// GPIO bus and interrupt assertions
`include "gpio_params.svh"

module gpio_sva (
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    i_req_valid,
  input  logic                    i_req_write,
  input  logic                    i_resp_valid,
  input  logic                    i_resp_err,
  input  logic [`GPIO_WIDTH-1:0]  i_gpio_dir,
  input  logic [`GPIO_WIDTH-1:0]  i_irq
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  resp_follows_req: assert property (
    @(posedge clk) disable iff (!nrst) i_resp_valid == $past(i_req_valid)
  ) else begin
    $error("response strobe is not the request strobe delayed by one cycle");
    fail_count++;
  end

  err_needs_valid: assert property (
    @(posedge clk) disable iff (!nrst) i_resp_err |-> i_resp_valid
  ) else begin
    $error("error flag raised without a response strobe");
    fail_count++;
  end

  // without a write, a new irq bit can only come from an input pin
  irq_from_inputs: assert property (
    @(posedge clk) disable iff (!nrst)
    !$past(i_req_valid && i_req_write) |->
      ((i_irq & ~$past(i_irq) & ~$past(i_gpio_dir)) == '0)
  ) else begin
    $error("interrupt raised on a pin configured as output");
    fail_count++;
  end

endmodule : gpio_sva

bind gpio_top gpio_sva u_sva (
  .clk          (clk),
  .nrst         (nrst),
  .i_req_valid  (i_req_valid),
  .i_req_write  (i_req_write),
  .i_resp_valid (o_resp_valid),
  .i_resp_err   (o_resp_err),
  .i_gpio_dir   (o_gpio_dir),
  .i_irq        (o_irq)
);

/* testbench/gpio_tb.sv */
// GPIO peripheral testbench
`include "gpio_params.svh"

module gpio_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESP_TIMEOUT = 20;  // cycles
  localparam int IRQ_TIMEOUT  = 20;
  localparam int SYNC_EDGES   = 3;   // two sync flops, then pending

  typedef struct packed {
    gpio_pkg::gpio_op_e          op;
    logic [`GPIO_ADDR_BITS-1:0]  addr;
    logic [`GPIO_DATA_BITS-1:0]  wdata;
    logic [`GPIO_STRB_BITS-1:0]  wstrb;
    logic [`GPIO_WIDTH-1:0]      pins;
    logic [`GPIO_DATA_BITS-1:0]  rdata;
    logic                        err;
    logic [`GPIO_WIDTH-1:0]      gpio;
    logic [`GPIO_WIDTH-1:0]      dir;
    logic [`GPIO_WIDTH-1:0]      irq;
  } row_t;

  logic                        clk;
  logic                        nrst;
  logic                        i_req_valid;
  logic                        i_req_write;
  logic [`GPIO_ADDR_BITS-1:0]  i_req_addr;
  logic [`GPIO_DATA_BITS-1:0]  i_req_wdata;
  logic [`GPIO_STRB_BITS-1:0]  i_req_wstrb;
  logic [`GPIO_WIDTH-1:0]      i_gpio;
  logic                        o_resp_valid;
  logic [`GPIO_DATA_BITS-1:0]  o_resp_rdata;
  logic                        o_resp_err;
  logic [`GPIO_WIDTH-1:0]      o_gpio;
  logic [`GPIO_WIDTH-1:0]      o_gpio_dir;
  logic [`GPIO_WIDTH-1:0]      o_irq;

  logic [`GPIO_DATA_BITS-1:0]  exp_rdata;
  logic                        exp_chk_rdata;
  logic                        exp_err;
  logic [`GPIO_WIDTH-1:0]      exp_gpio;
  logic [`GPIO_WIDTH-1:0]      exp_dir;
  logic [`GPIO_WIDTH-1:0]      exp_irq;
  int                          resp_count;
  int                          mismatch_count;

  row_t                        rows[$];
  logic [31:0]                 rng_state;
  logic [`GPIO_WIDTH-1:0]      want_gpio;  // pin outputs after the row
  logic [`GPIO_WIDTH-1:0]      want_dir;
  int                          other_errors;
  int                          requests;

  gpio_top UUT (
    .clk          (clk),
    .nrst         (nrst),
    .i_req_valid  (i_req_valid),
    .i_req_write  (i_req_write),
    .i_req_addr   (i_req_addr),
    .i_req_wdata  (i_req_wdata),
    .i_req_wstrb  (i_req_wstrb),
    .o_resp_valid (o_resp_valid),
    .o_resp_rdata (o_resp_rdata),
    .o_resp_err   (o_resp_err),
    .i_gpio       (i_gpio),
    .o_gpio       (o_gpio),
    .o_gpio_dir   (o_gpio_dir),
    .o_irq        (o_irq)
  );

  gpio_checker u_checker (
    .clk              (clk),
    .nrst             (nrst),
    .i_resp_valid     (o_resp_valid),
    .i_resp_rdata     (o_resp_rdata),
    .i_resp_err       (o_resp_err),
    .i_gpio_out       (o_gpio),
    .i_gpio_dir       (o_gpio_dir),
    .i_irq            (o_irq),
    .i_exp_rdata      (exp_rdata),
    .i_exp_chk_rdata  (exp_chk_rdata),
    .i_exp_err        (exp_err),
    .i_exp_gpio       (exp_gpio),
    .i_exp_dir        (exp_dir),
    .i_exp_irq        (exp_irq),
    .o_resp_count     (resp_count),
    .o_mismatch_count (mismatch_count)
  );

  always #2 clk = ~clk;  // 4 ns period

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [`GPIO_WIDTH-1:0] next_pattern();
    rng_state = xorshift(rng_state);
    return rng_state[`GPIO_WIDTH-1:0];
  endfunction

  task automatic add_row(input gpio_pkg::gpio_op_e op, input logic [11:0] addr,
                         input logic [63:0] wdata, input logic [7:0] wstrb,
                         input logic [11:0] pins, input logic [63:0] rdata,
                         input logic err, input logic [11:0] irq);
    row_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = wdata;
    r.wstrb = wstrb;
    r.pins  = pins;
    r.rdata = rdata;
    r.err   = err;
    r.gpio  = want_gpio;
    r.dir   = want_dir;
    r.irq   = irq;
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [11:0] pat1;
    logic [11:0] pat2;
    pat1 = next_pattern();
    pat2 = next_pattern() | 12'h804;  // pin 11 is an output, pin 2 an enabled input
    want_gpio = 12'h000;
    want_dir  = 12'hfff;
    add_row(gpio_pkg::op_read, 12'h000, '0, 8'h00, 12'h000, 64'h0fff, 1'b0, 12'h000);
    add_row(gpio_pkg::op_read, 12'h008, '0, 8'h00, 12'h000, 64'h0, 1'b0, 12'h000);
    add_row(gpio_pkg::op_read, 12'h010, '0, 8'h00, 12'h000, 64'h0, 1'b0, 12'h000);
    want_dir = 12'ha5f;
    add_row(gpio_pkg::op_write, 12'h000, 64'hffff_ffff_0000_0a5f, 8'h0f, 12'h000,
            '0, 1'b0, 12'h000);
    add_row(gpio_pkg::op_write, 12'h008, 64'h1234_5678_0000_0c3c, 8'hf0, 12'h000,
            '0, 1'b0, 12'h000);  // scratch only
    want_gpio = 12'hff0;
    add_row(gpio_pkg::op_write, 12'h008, 64'hdead_beef_0000_0ff0, 8'h01, 12'h000,
            '0, 1'b0, 12'h000);
    add_row(gpio_pkg::op_read, 12'h008, '0, 8'h00, 12'h000, 64'h1234_5678_0000_0ff0,
            1'b0, 12'h000);
    add_row(gpio_pkg::op_write, 12'h000, 64'h0, 8'h80, 12'h000, '0, 1'b0, 12'h000);
    want_dir = 12'h0ff;
    add_row(gpio_pkg::op_write, 12'h000, 64'h00ff, 8'h02, 12'h000, '0, 1'b0, 12'h000);
    add_row(gpio_pkg::op_read, 12'h000, '0, 8'h00, 12'h000, 64'h00ff, 1'b0, 12'h000);
    // input levels, pending without enable
    add_row(gpio_pkg::op_read, 12'h000, '0, 8'h00, pat1, {20'h0, pat1, 20'h0, 12'h0ff},
            1'b0, 12'h000);
    add_row(gpio_pkg::op_read, 12'h010, '0, 8'h00, pat1, {20'h0, pat1 & 12'h0ff, 32'h0},
            1'b0, 12'h000);
    add_row(gpio_pkg::op_write, 12'h010, {20'h0, 12'hfff, 32'h0}, 8'hf0, pat1,
            '0, 1'b0, 12'h000);
    add_row(gpio_pkg::op_write, 12'h010, 64'h0f3c, 8'h0f, pat1, '0, 1'b0, 12'h000);
    // rising edges with enable set
    add_row(gpio_pkg::op_none, 12'h000, '0, 8'h00, 12'h000, '0, 1'b0, 12'h000);
    add_row(gpio_pkg::op_none, 12'h000, '0, 8'h00, pat2, '0, 1'b0, pat2 & 12'h03c);
    add_row(gpio_pkg::op_read, 12'h010, '0, 8'h00, pat2,
            {20'h0, pat2 & 12'h0ff, 20'h0, 12'hf3c}, 1'b0, pat2 & 12'h03c);
    add_row(gpio_pkg::op_write, 12'h010, {20'h0, 12'h0a5, 32'h0}, 8'h10, pat2,
            '0, 1'b0, pat2 & 12'h018);
    add_row(gpio_pkg::op_read, 12'h010, '0, 8'h00, pat2,
            {20'h0, pat2 & 12'h05a, 20'h0, 12'hf3c}, 1'b0, pat2 & 12'h018);
    // unmapped words
    add_row(gpio_pkg::op_read, 12'h018, '0, 8'h00, pat2, 64'h0, 1'b1, pat2 & 12'h018);
    add_row(gpio_pkg::op_write, 12'hff8, '1, 8'hff, pat2, 64'h0, 1'b1, pat2 & 12'h018);
    add_row(gpio_pkg::op_write, 12'h018, '1, 8'hff, pat2, 64'h0, 1'b1, pat2 & 12'h018);
    add_row(gpio_pkg::op_read, 12'h000, '0, 8'h00, pat2, {20'h0, pat2, 20'h0, 12'h0ff},
            1'b0, pat2 & 12'h018);
    add_row(gpio_pkg::op_read, 12'h008, '0, 8'h00, pat2, 64'h1234_5678_0000_0ff0,
            1'b0, pat2 & 12'h018);
    add_row(gpio_pkg::op_read, 12'h010, '0, 8'h00, pat2,
            {20'h0, pat2 & 12'h05a, 20'h0, 12'hf3c}, 1'b0, pat2 & 12'h018);
  endtask

  task automatic settle_pins(input logic [11:0] pins, input logic [11:0] irq);
    int cyc;
    @(negedge clk);
    i_gpio = pins;
    cyc = 0;
    while ((cyc < SYNC_EDGES || o_irq !== irq) && cyc < IRQ_TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (o_irq !== irq) begin
      $display("o_irq stuck at %h after %0d cycles, waiting for %h", o_irq, IRQ_TIMEOUT, irq);
      other_errors++;
    end
  endtask

  task automatic run_access(input row_t r);
    int cyc;
    int seen;
    seen = resp_count;
    @(negedge clk);
    exp_rdata     = r.rdata;
    exp_chk_rdata = (r.op == gpio_pkg::op_read) || r.err;  // write data echoes old contents
    exp_err       = r.err;
    exp_gpio      = r.gpio;
    exp_dir       = r.dir;
    exp_irq       = r.irq;
    i_req_valid   = 1'b1;
    i_req_write   = (r.op == gpio_pkg::op_write);
    i_req_addr    = r.addr;
    i_req_wdata   = r.wdata;
    i_req_wstrb   = r.wstrb;
    requests++;
    @(negedge clk);
    i_req_valid = 1'b0;
    cyc = 0;
    while (resp_count == seen && cyc < RESP_TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (resp_count == seen) begin
      $display("no response to the access at address %h within %0d cycles", r.addr, cyc);
      other_errors++;
    end
  endtask

  initial begin
    clk           = 1'b0;
    nrst          = 1'b0;
    i_req_valid   = 1'b0;
    i_req_write   = 1'b0;
    i_req_addr    = '0;
    i_req_wdata   = '0;
    i_req_wstrb   = '0;
    i_gpio        = '0;
    exp_rdata     = '0;
    exp_chk_rdata = 1'b0;
    exp_err       = 1'b0;
    exp_gpio      = '0;
    exp_dir       = '0;
    exp_irq       = '0;
    rng_state     = 32'ha75c_0649;
    other_errors  = 0;
    requests      = 0;
    build_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    nrst = 1'b1;
    foreach (rows[i]) begin
      if (rows[i].op == gpio_pkg::op_none || rows[i].pins !== i_gpio) begin
        settle_pins(rows[i].pins, rows[i].irq);
      end
      if (rows[i].op != gpio_pkg::op_none) begin
        run_access(rows[i]);
      end
    end
    @(negedge clk);
    if (resp_count != requests) begin
      $display("%0d requests issued but %0d responses seen", requests, resp_count);
      other_errors++;
    end
    $display("errors: %0d mismatches, %0d other, %0d assertion failures",
             mismatch_count, other_errors, UUT.u_sva.fail_count);
    if (mismatch_count == 0 && other_errors == 0 && UUT.u_sva.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : gpio_tb

/* tb.f */
+incdir+source
source/gpio_pkg.sv
source/gpio_req_if.sv
source/gpio_in_sync.sv
source/gpio_ctrl.sv
source/gpio_regs.sv
source/gpio_top.sv
testbench/gpio_checker.sv
testbench/gpio_sva.sv
testbench/gpio_tb.sv
